// File: hw/hdr_byte_counter.sv
// Beat counter of the header generator, gives the byte position and flags the final byte

`timescale 1ns/100ps
`default_nettype none

`include "hdr_gen_macros.svh"

module hdr_byte_counter
    import hdr_gen_pkg::*;
(
    input  wire logic  clock,
    input  wire logic  rst_n,
    input  wire logic  valid,
    input  wire logic  ready,
    output hdr_index_t byte_index,
    output logic       last_byte,
    output logic       frame_done
);

    localparam hdr_index_t LAST_INDEX = hdr_index_t'(`HDR_BYTES - 1);

    logic beat;

    // --------------------
    // Beat detection
    // --------------------

    // A byte moves only when both sides agree
    assign beat = valid && ready;

    // Index rests at 0 between frames, so this is low outside a frame
    assign last_byte = (byte_index == LAST_INDEX);

    // Pulse on the transfer of the final byte
    assign frame_done = beat && last_byte;

    // --------------------
    // Position counter
    // --------------------

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            byte_index <= '0;
        end else if (beat) begin
            if (last_byte) begin
                // Wrap for the next frame
                byte_index <= '0;
            end else begin
                byte_index <= byte_index + hdr_index_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/hdr_byte_source.sv
// Header snapshot register of the generator, presents the byte at the current position

`timescale 1ns/100ps
`default_nettype none

`include "hdr_gen_macros.svh"

module hdr_byte_source
    import hdr_gen_pkg::*;
(
    input  wire logic       clock,
    input  wire logic       rst_n,
    input  wire logic       start,
    input  wire ip_header_t fields,
    input  wire hdr_index_t byte_index,
    output hdr_byte_t       data
);

    localparam hdr_index_t TOP_INDEX = hdr_index_t'(`HDR_BYTES - 1);

    // Captured header viewed as bytes, element 19 is the first on the wire
    hdr_byte_t [`HDR_BYTES-1:0] hdr_q;

    hdr_index_t sel_index;

    // --------------------
    // Snapshot
    // --------------------

    // Loaded once per frame, later field changes wait for the next frame
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            hdr_q <= '0;
        end else if (start) begin
            hdr_q <= fields;
        end
    end

    // --------------------
    // Byte select
    // --------------------

    // Frame byte 0 is the most significant byte of the struct
    assign sel_index = TOP_INDEX - byte_index;

    // Follows the index in the same cycle, held while the index holds
    assign data = hdr_q[sel_index];

endmodule

`default_nettype wire

// File: hw/hdr_gen_fsm.sv
// Frame control FSM of the header generator, accepts a request and drives the stream valid

`timescale 1ns/100ps
`default_nettype none

module hdr_gen_fsm
    import hdr_gen_pkg::*;
(
    input  wire logic clock,
    input  wire logic rst_n,
    input  wire logic enable,
    input  wire logic ready,
    input  wire logic frame_done,
    output logic      valid,
    output logic      start
);

    gen_state_t state_q;
    gen_state_t state_d;

    // --------------------
    // Start condition
    // --------------------

    // A frame begins only from idle, with a request and a ready sink
    assign start = (state_q == GEN_IDLE) && enable && ready;

    // --------------------
    // Next state
    // --------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            GEN_IDLE: begin
                if (start) begin
                    state_d = GEN_SEND;
                end
            end
            GEN_SEND: begin
                // Leave on the beat of the final byte
                if (frame_done) begin
                    state_d = GEN_DONE;
                end
            end
            GEN_DONE: begin
                // Gap cycle before the next request is seen
                state_d = GEN_IDLE;
            end
            default: begin
                state_d = GEN_IDLE;
            end
        endcase
    end

    // --------------------
    // State register
    // --------------------

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= GEN_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Stream valid for the whole sending phase
    assign valid = (state_q == GEN_SEND);

endmodule

`default_nettype wire

// File: hw/hdr_gen_macros.svh
// Fixed IPv4 header geometry constants, included by the package, RTL and testbench

`ifndef HDR_GEN_MACROS_SVH
`define HDR_GEN_MACROS_SVH

// --------------------
// Header geometry
// --------------------

// Bytes in one IPv4 header without options
`define HDR_BYTES 20

// Width of one stream beat
`define HDR_BYTE_W 8

// Total header width in bits
`define HDR_BITS (`HDR_BYTES * `HDR_BYTE_W)

`endif

// File: hw/hdr_gen_pkg.sv
// Shared types of the IPv4 header generator, imported by every RTL module and the testbench

`default_nettype none

`include "hdr_gen_macros.svh"

package hdr_gen_pkg;

    // --------------------
    // Stream types
    // --------------------

    // One byte on the output stream
    typedef logic [`HDR_BYTE_W-1:0] hdr_byte_t;

    // Byte position inside a header, 0 to 19
    typedef logic [4:0] hdr_index_t;

    // --------------------
    // Header fields
    // --------------------

    // Declared in wire order, so the first field sits in the top bits
    typedef struct packed {
        logic [7:0]  version_ihl;
        logic [7:0]  tos;
        logic [15:0] total_length;
        logic [15:0] identification;
        logic [15:0] flags_fragment;   // Flags and fragment offset together
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] header_checksum;
        logic [31:0] src_addr;
        logic [31:0] dst_addr;
    } ip_header_t;

    // --------------------
    // Control
    // --------------------

    // Generator FSM states
    typedef enum logic [1:0] {
        GEN_IDLE = 2'd0,
        GEN_SEND = 2'd1,
        GEN_DONE = 2'd2
    } gen_state_t;

endpackage

`default_nettype wire

// File: hw/ip_header_gen.sv
// Top of the IPv4 header generator, streams a 20 byte header per request on a valid/ready bus

`timescale 1ns/100ps
`default_nettype none

module ip_header_gen
    import hdr_gen_pkg::*;
(
    input  wire logic       clock,
    input  wire logic       rst_n,
    input  wire logic       enable,
    input  wire ip_header_t fields,
    input  wire logic       ready,
    output hdr_byte_t       data,
    output logic            valid,
    output logic            last
);

    // --------------------
    // Internal nets
    // --------------------

    logic       start;
    logic       frame_done;
    logic       last_byte;
    hdr_index_t byte_index;

    // Final byte marker straight from the counter
    assign last = last_byte;

    // --------------------
    // Frame control
    // --------------------

    hdr_gen_fsm u_fsm (
        .clock      (clock),
        .rst_n      (rst_n),
        .enable     (enable),
        .ready      (ready),
        .frame_done (frame_done),
        .valid      (valid),
        .start      (start)
    );

    // --------------------
    // Byte position
    // --------------------

    hdr_byte_counter u_counter (
        .clock      (clock),
        .rst_n      (rst_n),
        .valid      (valid),
        .ready      (ready),
        .byte_index (byte_index),
        .last_byte  (last_byte),
        .frame_done (frame_done)
    );

    // --------------------
    // Header bytes
    // --------------------

    // Snapshot taken on the start edge
    hdr_byte_source u_source (
        .clock      (clock),
        .rst_n      (rst_n),
        .start      (start),
        .fields     (fields),
        .byte_index (byte_index),
        .data       (data)
    );

endmodule

`default_nettype wire

// File: project.f
+incdir+hw
+incdir+sim
hw/hdr_gen_pkg.sv
hw/hdr_gen_fsm.sv
hw/hdr_byte_counter.sv
hw/hdr_byte_source.sv
hw/ip_header_gen.sv
sim/ip_header_gen_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the header generator testbench with Verilator, runs it and checks the log

set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
SIM_BIN=ip_header_gen_sim
LOG_FILE=sim.log

verilator --binary --timing \
    -f project.f \
    --top-module ip_header_gen_tb \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1

cat "$LOG_FILE"

if grep -q "Result: PASSED" "$LOG_FILE"; then
    echo "Simulation passed"
else
    echo "Simulation failed, see $LOG_FILE"
    exit 1
fi

// File: sim/ip_header_vectors.svh
// Stimulus table of the header generator testbench, included inside the testbench module body

`ifndef IP_HEADER_VECTORS_SVH
`define IP_HEADER_VECTORS_SVH

// One table row, the header in the top bits
typedef struct packed {
    ip_header_t hdr;
    logic       random_ready;   // Sink stalls at random when set
    logic       change_fields;  // Next row goes onto the inputs after the first beat
} vec_row_t;

localparam int NUM_ROWS = 6;

vec_row_t vectors [NUM_ROWS];

// Columns: header in wire order, random ready, field change during the frame
task automatic load_vectors();
    vectors[0] = {160'h4500_0054_1c46_4000_4001_b1e6_c0a8_0001_c0a8_00c7, 1'b0, 1'b0};
    vectors[1] = {160'h4510_003c_abcd_0000_8006_1234_0a00_0001_0a00_0002, 1'b1, 1'b0};
    vectors[2] = {160'h45ff_ffff_0001_2000_ff11_ffff_ffff_ffff_0000_0000, 1'b0, 1'b1};
    vectors[3] = {160'h4600_0028_5a5a_3fff_0132_a5a5_1234_5678_9abc_def0, 1'b1, 1'b1};
    vectors[4] = {160'h4500_05dc_8000_0123_4006_0000_ac10_0a01_ac10_0afe, 1'b1, 1'b0};
    // Last row keeps its fields, no frame follows it
    vectors[5] = {160'h4f0c_0100_7e7e_c000_3c2f_5555_0102_0304_f1f2_f3f4, 1'b0, 1'b0};
endtask

`endif

// File: sim/ip_header_gen_tb.sv
// Self-checking simulation top that streams table frames through the IPv4 header generator

`timescale 1ns/100ps
`default_nettype none

`include "hdr_gen_macros.svh"

module ip_header_gen_tb
    import hdr_gen_pkg::*;
();

    logic       clock;
    logic       rst_n;
    logic       enable;
    logic       ready;
    ip_header_t fields;
    hdr_byte_t  data;
    logic       valid;
    logic       last;

    int mismatch_count;
    int failure_count;
    int cycle_count;

    `include "ip_header_vectors.svh"

    // Generous bound per frame for random stalls
    localparam int TIMEOUT_CYCLES = NUM_ROWS * `HDR_BYTES * 8 + 100;

    ip_header_gen dut (
        .clock  (clock),
        .rst_n  (rst_n),
        .enable (enable),
        .fields (fields),
        .ready  (ready),
        .data   (data),
        .valid  (valid),
        .last   (last)
    );

    // --------------------
    // Clock and watchdog
    // --------------------

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the frame sequence did not complete", cycle_count);
        $display("Result: FAILED");
        $finish;
    end

    // --------------------
    // Compare tasks
    // --------------------

    task automatic check_byte(input string name, input hdr_byte_t got, input hdr_byte_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch %s: got 0x%02h, expected 0x%02h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch %s: got 0x%01h, expected 0x%01h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_failure(input string msg);
        failure_count++;
        $display("Error: %s at %0t", msg, $time);
    endtask

    // --------------------
    // Reference model
    // --------------------

    // Byte i is bits 159-8i down to 152-8i of the header
    function automatic hdr_byte_t expected_byte(input ip_header_t hdr, input int pos);
        int top;
        top = `HDR_BITS - 1 - `HDR_BYTE_W * pos;
        return hdr[top -: `HDR_BYTE_W];
    endfunction

    function automatic logic pick_ready(input logic random_ready);
        if (random_ready) begin
            return ($urandom % 2) != 0;
        end
        return 1'b1;
    endfunction

    // --------------------
    // Drivers
    // --------------------

    // Cycles in which no frame may be running
    task automatic check_quiet(input logic en, input logic rdy, input int cycles,
                               input string what);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clock);
            enable = en;
            ready = rdy;
            #1;
            if (valid !== 1'b0) begin
                report_failure({"valid went high ", what});
            end
            check_flag("last", last, 1'b0);
        end
    endtask

    // Requests one frame and checks every beat against the row
    task automatic run_frame(input int row_idx);
        vec_row_t  row;
        int        beats;
        logic      stalled;
        logic      seen_valid;
        logic      start_ok;
        hdr_byte_t held_data;
        logic      held_last;
        row = vectors[row_idx];
        beats = 0;
        stalled = 1'b0;
        seen_valid = 1'b0;
        start_ok = 1'b0;
        held_data = '0;
        held_last = 1'b0;
        while (beats < `HDR_BYTES) begin
            @(negedge clock);
            if (!seen_valid) begin
                fields = row.hdr;
                enable = 1'b1;
            end else begin
                enable = 1'b0;
            end
            // Inputs may move on once the snapshot is taken
            if (beats >= 1 && row.change_fields) begin
                fields = vectors[(row_idx + 1) % NUM_ROWS].hdr;
            end
            ready = pick_ready(row.random_ready);
            #1;
            if (stalled) begin
                check_byte("data held in stall", data, held_data);
                check_flag("last held in stall", last, held_last);
            end
            if (valid === 1'b1 && !seen_valid) begin
                if (!start_ok) begin
                    report_failure("frame started without enable and ready both high");
                end
                seen_valid = 1'b1;
            end else if (valid !== 1'b1 && seen_valid) begin
                report_failure("valid dropped before the frame ended");
                break;
            end
            if (valid !== 1'b1) begin
                check_flag("last", last, 1'b0);
            end
            start_ok = enable && ready;
            stalled = valid && !ready;
            held_data = data;
            held_last = last;
            if (valid === 1'b1 && ready) begin
                check_byte("data", data, expected_byte(row.hdr, beats));
                check_flag("last", last, beats == `HDR_BYTES - 1);
                beats++;
            end
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        void'($urandom(32'h11e5));
        mismatch_count = 0;
        failure_count = 0;
        rst_n = 1'b0;
        enable = 1'b0;
        ready = 1'b0;
        fields = '0;
        load_vectors();

        // Outputs quiet through reset
        for (int i = 0; i < 3; i++) begin
            @(posedge clock);
            #1;
            if (valid !== 1'b0) begin
                report_failure("valid high during reset");
            end
            check_flag("last during reset", last, 1'b0);
        end
        @(negedge clock);
        rst_n = 1'b1;

        check_quiet(1'b0, 1'b0, 2, "right after reset");
        check_quiet(1'b1, 1'b0, 6, "with ready held low");
        check_quiet(1'b0, 1'b1, 6, "with enable low");

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_frame(r);
            // Done cycle, then idle without a request
            check_quiet(1'b0, 1'b1, 2, "in the gap after a frame");
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
